/* bench/alu_tb.sv */
`timescale 1ns/1ps

module alu_tb;
	import alu_pkg::*;

	localparam int apb_timeout = 16;
	localparam logic [3:0] arith_ops [8] = '{op_add, op_sub, op_add_again, op_and,
		op_orr, op_xor, op_inv, op_not};
	localparam logic [3:0] unused_ops [5] = '{4'd3, 4'd4, 4'd13, 4'd14, 4'd15};
	// unmapped read, unmapped write, then writes to both result registers
	localparam logic [7:0] bad_addr [4] = '{8'h1C, 8'hF0, reg_result_lo, reg_result_hi};

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic psel = 1'b0;
	logic penable = 1'b0;
	logic pwrite = 1'b0;
	logic [apb_addr_width-1:0] paddr = '0;
	logic [apb_data_width-1:0] pwdata = '0;
	logic [apb_data_width-1:0] prdata;
	logic pready;
	logic pslverr;
	int errors = 0;
	int checks = 0;
	logic timed_out = 1'b0;

	alu_top alu_top_i (.*);

	always #50 clk = ~clk;

	// one APB transfer, outputs sampled in the middle of the access cycle
	task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int waited;
		waited = 0;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready && waited < apb_timeout)
		begin
			@(negedge clk);
			waited++;
		end
		if (!pready && !timed_out)
			$display("no pready from the DUT after %0d cycles at address %h", apb_timeout, addr);
		timed_out = timed_out | !pready;
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
		checks++;
		assert (timed_out || got === exp)
		else
		begin
			errors++;
			$display("mismatch at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic logic [63:0] rand64();
		return {$urandom(), $urandom()};
	endfunction

	// operands cut to the selected width, result zero-extended
	function automatic logic [63:0] expected_result(input logic [63:0] a, input logic [63:0] b,
		input logic [3:0] oper, input logic sgn, input logic [1:0] wsel);
		int w;
		logic [63:0] mask;
		logic [63:0] am;
		logic [63:0] bm;
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [63:0] r;
		w = 8 << wsel;
		mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
		am = a & mask;
		bm = b & mask;
		// sign-extended copies for the signed compare and arithmetic shift
		sa = am[w-1] ? (am | ~mask) : am;
		sb = bm[w-1] ? (bm | ~mask) : bm;
		case (oper)
		op_add, op_add_again: r = am + bm;
		op_sub: r = am - bm;
		op_slt: r = sgn ? 64'(sa < sb) : 64'(am < bm);
		op_and: r = am & bm;
		op_orr: r = am | bm;
		op_xor: r = am ^ bm;
		op_shl: r = (bm >= 64'(w)) ? '0 : (am << bm);
		op_shr:
		begin
			if (bm >= 64'(w))
				r = (sgn && am[w-1]) ? '1 : '0;
			else if (sgn)
				r = sa >>> bm;
			else
				r = am >> bm;
		end
		op_inv: r = ~am;
		op_not: r = 64'(am == 64'd0);
		default: r = '0;
		endcase
		return r & mask;
	endfunction

	// program operands and control, then read back the latched result
	task automatic run_op(input logic [63:0] a, input logic [63:0] b, input logic [3:0] oper,
		input logic sgn, input logic [1:0] wsel, output logic [63:0] got);
		logic [7:0] addrs [5] = '{reg_a_lo, reg_a_hi, reg_b_lo, reg_b_hi, reg_ctrl};
		logic [31:0] words [5];
		logic [31:0] lo;
		logic [31:0] hi;
		logic err;
		logic any_err;
		words = '{a[31:0], a[63:32], b[31:0], b[63:32], {25'd0, wsel, sgn, oper}};
		any_err = 1'b0;
		for (int k = 0; k < 5; k++)
		begin
			apb_xfer(1'b1, addrs[k], words[k], lo, err);
			any_err = any_err | err;
		end
		apb_xfer(1'b0, reg_result_lo, 32'd0, lo, err);
		any_err = any_err | err;
		apb_xfer(1'b0, reg_result_hi, 32'd0, hi, err);
		any_err = any_err | err;
		got = {hi, lo};
		check_value(64'(any_err), 64'd0, "pslverr on a mapped register");
		check_value(got, expected_result(a, b, oper, sgn, wsel),
			$sformatf("op %0d signed %0b width %0d a %h b %h", oper, sgn, wsel, a, b));
	endtask

	initial
	begin
		logic [63:0] got;
		logic [63:0] sres;
		logic [63:0] ures;
		logic [63:0] top;
		logic [63:0] amounts [5];
		logic [63:0] op_a;
		logic [63:0] op_b;
		logic [31:0] data;
		logic err;
		int width_bits;
		void'($urandom(32'h3551));
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		apb_xfer(1'b0, reg_result_lo, 32'd0, data, err);
		check_value(64'({err, data}), 64'd0, "result_lo after reset");
		apb_xfer(1'b0, reg_result_hi, 32'd0, data, err);
		check_value(64'({err, data}), 64'd0, "result_hi after reset");

		for (int w = 0; w < 4; w++)
		begin
			for (int k = 0; k < 8; k++)
				for (int n = 0; n < 5; n++)
					run_op(rand64(), rand64(), arith_ops[k], 1'($urandom()), 2'(w), got);
			// all ones plus one wraps at every width
			run_op('1, 64'd1, op_add, 1'b0, 2'(w), got);
			check_value(got, 64'd0, "add wrap-around");
			// only bits above the width set, so not sees a zero operand
			run_op(64'd1 << (8 << w), rand64(), op_not, 1'b0, 2'(w), got);
			check_value(got, 64'd1, "not of zero");
		end

		for (int w = 0; w < 4; w++)
		begin
			for (int n = 0; n < 8; n++)
				run_op(rand64(), rand64(), op_slt, 1'(n), 2'(w), got);
			// only the top bit set, negative when signed
			top = 64'd1 << ((8 << w) - 1);
			run_op(top, 64'd0, op_slt, 1'b1, 2'(w), sres);
			run_op(top, 64'd0, op_slt, 1'b0, 2'(w), ures);
			check_value(64'(sres != ures), 64'd1, "signed and unsigned compare agree");
		end

		// zero, inside, at and beyond the width, and all ones
		for (int w = 0; w < 4; w++)
		begin
			width_bits = 8 << w;
			amounts = '{64'd0, 64'($urandom_range(width_bits - 1, 1)), 64'(width_bits),
				64'(width_bits + $urandom_range(63, 1)), '1};
			for (int k = 0; k < 5; k++)
				for (int n = 0; n < 4; n++)
					run_op(rand64() | (64'(n == 3) << (width_bits - 1)), amounts[k],
						n < 2 ? op_shl : op_shr, 1'(n), 2'(w), got);
		end

		for (int k = 0; k < 5; k++)
		begin
			run_op(rand64(), rand64(), unused_ops[k], 1'($urandom()), 2'($urandom()), got);
			check_value(got, 64'd0, "unused opcode");
		end

		op_a = rand64();
		op_b = rand64();
		run_op(op_a, op_b, op_xor, 1'b0, w64, got);
		for (int k = 0; k < 4; k++)
		begin
			apb_xfer(k != 0, bad_addr[k], $urandom(), data, err);
			check_value(64'(err), 64'd1, $sformatf("pslverr at address %h", bad_addr[k]));
		end
		// new operands without a control write keep the old result
		apb_xfer(1'b1, reg_a_lo, $urandom(), data, err);
		apb_xfer(1'b1, reg_b_hi, $urandom(), data, err);
		apb_xfer(1'b0, reg_result_lo, 32'd0, data, err);
		check_value(64'(data), (op_a ^ op_b) & 64'hFFFF_FFFF, "result_lo after operand writes");
		apb_xfer(1'b0, reg_result_hi, 32'd0, data, err);
		check_value(64'(data), (op_a ^ op_b) >> 32, "result_hi after operand writes");

		$display("%0d checks, %0d errors, timeout %0b", checks, errors, timed_out);
		if (errors == 0 && !timed_out)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* hdl/alu_core.sv */
`timescale 1ns/1ps

module alu_core #(parameter int width = 64)
(
	input logic [width-1:0] a,
	input logic [width-1:0] b,
	input alu_pkg::alu_oper_t oper,
	input logic signedness,
	output logic [width-1:0] result
);
	import alu_pkg::*;

	// width is a power of two, so the low bits of b index every position
	localparam int amt_width = $clog2(width);

	logic [amt_width-1:0] shamt;
	logic shift_out;
	logic slt_signed;
	logic slt_unsigned;
	logic [width-1:0] shl_val;
	logic [width-1:0] shr_logic;
	logic [width-1:0] shr_arith;
	logic [width-1:0] sra_raw;

	// any upper bit of b shifts everything out
	assign shamt = b[amt_width-1:0];
	assign shift_out = |b[width-1:amt_width];

	// kept apart so the signed compare is not widened to unsigned
	assign slt_signed = $signed(a) < $signed(b);
	assign slt_unsigned = a < b;

	assign sra_raw = $signed(a) >>> shamt;

	assign shl_val = shift_out ? '0 : (a << shamt);
	assign shr_logic = shift_out ? '0 : (a >> shamt);
	// all sign bits once the amount reaches the width
	assign shr_arith = shift_out ? {width{a[width-1]}} : sra_raw;

	always_comb
	begin
		case (oper)
		op_add, op_add_again:
		begin
			result = a + b;
		end
		op_sub:
		begin
			result = a - b;
		end
		op_slt:
		begin
			if (signedness)
			begin
				result = {{(width-1){1'b0}}, slt_signed};
			end
			else
			begin
				result = {{(width-1){1'b0}}, slt_unsigned};
			end
		end
		op_and:
		begin
			result = a & b;
		end
		op_orr:
		begin
			result = a | b;
		end
		op_xor:
		begin
			result = a ^ b;
		end
		op_shl:
		begin
			result = shl_val;
		end
		op_shr:
		begin
			result = signedness ? shr_arith : shr_logic;
		end
		op_inv:
		begin
			result = ~a;
		end
		op_not:
		begin
			// 1 only for a zero operand
			result = {{(width-1){1'b0}}, ~|a};
		end
		default:
		begin
			result = '0;
		end
		endcase
	end

endmodule

/* hdl/alu_ctrl_if.sv */
`timescale 1ns/1ps

interface alu_ctrl_if;
	import alu_pkg::*;

	// operands as written over APB, full width
	logic [data_width-1:0] a;
	logic [data_width-1:0] b;

	// decoded control word
	alu_oper_t oper;
	logic signedness;
	alu_width_t width;

	// zero-extended result, valid in the same cycle as the inputs
	logic [data_width-1:0] result;

	modport regs
	(
		output a, b, oper, signedness, width,
		input result
	);

	modport datapath
	(
		input a, b, oper, signedness, width,
		output result
	);

endinterface

/* hdl/alu_pkg.sv */
package alu_pkg;

	// datapath and bus widths
	localparam int data_width = 64;
	localparam int apb_data_width = 32;
	localparam int apb_addr_width = 8;

	// opcode encodings, gaps at 3, 4 and 13 to 15 give zero
	typedef enum logic [3:0]
	{
		op_add = 4'd0,
		op_sub = 4'd1,
		op_slt = 4'd2,
		op_and = 4'd5,
		op_orr = 4'd6,
		op_xor = 4'd7,
		op_shl = 4'd8,
		op_shr = 4'd9,
		op_inv = 4'd10,
		op_not = 4'd11,
		op_add_again = 4'd12
	} alu_oper_t;

	// operand width select
	typedef enum logic [1:0]
	{
		w8 = 2'd0,
		w16 = 2'd1,
		w32 = 2'd2,
		w64 = 2'd3
	} alu_width_t;

	// register map, byte offsets
	localparam logic [apb_addr_width-1:0] reg_a_lo = 8'h00;
	localparam logic [apb_addr_width-1:0] reg_a_hi = 8'h04;
	localparam logic [apb_addr_width-1:0] reg_b_lo = 8'h08;
	localparam logic [apb_addr_width-1:0] reg_b_hi = 8'h0C;
	localparam logic [apb_addr_width-1:0] reg_ctrl = 8'h10;
	localparam logic [apb_addr_width-1:0] reg_result_lo = 8'h14;
	localparam logic [apb_addr_width-1:0] reg_result_hi = 8'h18;

	// fields of the control word
	localparam int ctrl_oper_lsb = 0;
	localparam int ctrl_oper_msb = 3;
	localparam int ctrl_signed_bit = 4;
	localparam int ctrl_width_lsb = 5;
	localparam int ctrl_width_msb = 6;

endpackage

/* hdl/alu_regs.sv */
`timescale 1ns/1ps

module alu_regs
(
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [alu_pkg::apb_addr_width-1:0] paddr,
	input logic [alu_pkg::apb_data_width-1:0] pwdata,
	output logic [alu_pkg::apb_data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,
	alu_ctrl_if.regs ctrl
);
	import alu_pkg::*;

	logic [data_width-1:0] a_q;
	logic [data_width-1:0] b_q;
	logic [data_width-1:0] result_q;
	alu_oper_t oper_q;
	logic signed_q;
	alu_width_t width_q;
	logic result_pending;
	logic access;
	logic addr_mapped;
	logic addr_result;
	logic wr_en;

	// second phase of an APB transfer
	assign access = psel & penable;

	// address decode
	always_comb
	begin
		addr_mapped = 1'b1;
		addr_result = 1'b0;
		case (paddr)
		reg_a_lo, reg_a_hi, reg_b_lo, reg_b_hi, reg_ctrl:
		begin
			addr_result = 1'b0;
		end
		reg_result_lo, reg_result_hi:
		begin
			addr_result = 1'b1;
		end
		default:
		begin
			addr_mapped = 1'b0;
		end
		endcase
	end

	// result registers are read only
	assign wr_en = access & pwrite & addr_mapped & ~addr_result;
	assign pslverr = access & (~addr_mapped | (pwrite & addr_result));

	// never any wait states
	assign pready = 1'b1;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			a_q <= '0;
			b_q <= '0;
			oper_q <= op_add;
			signed_q <= 1'b0;
			width_q <= w8;
			result_pending <= 1'b0;
			result_q <= '0;
		end
		else
		begin
			// datapath sees the new control one cycle after the write
			result_pending <= wr_en && (paddr == reg_ctrl);
			if (result_pending)
			begin
				result_q <= ctrl.result;
			end

			if (wr_en)
			begin
				case (paddr)
				reg_a_lo:
				begin
					a_q[apb_data_width-1:0] <= pwdata;
				end
				reg_a_hi:
				begin
					a_q[data_width-1:apb_data_width] <= pwdata;
				end
				reg_b_lo:
				begin
					b_q[apb_data_width-1:0] <= pwdata;
				end
				reg_b_hi:
				begin
					b_q[data_width-1:apb_data_width] <= pwdata;
				end
				reg_ctrl:
				begin
					oper_q <= alu_oper_t'(pwdata[ctrl_oper_msb:ctrl_oper_lsb]);
					signed_q <= pwdata[ctrl_signed_bit];
					width_q <= alu_width_t'(pwdata[ctrl_width_msb:ctrl_width_lsb]);
				end
				default:
				begin
				end
				endcase
			end
		end
	end

	// read data in the access cycle
	always_comb
	begin
		prdata = '0;
		if (psel && !pwrite)
		begin
			case (paddr)
			reg_a_lo: prdata = a_q[apb_data_width-1:0];
			reg_a_hi: prdata = a_q[data_width-1:apb_data_width];
			reg_b_lo: prdata = b_q[apb_data_width-1:0];
			reg_b_hi: prdata = b_q[data_width-1:apb_data_width];
			reg_ctrl:
			begin
				prdata[ctrl_oper_msb:ctrl_oper_lsb] = oper_q;
				prdata[ctrl_signed_bit] = signed_q;
				prdata[ctrl_width_msb:ctrl_width_lsb] = width_q;
			end
			reg_result_lo: prdata = result_q[apb_data_width-1:0];
			reg_result_hi: prdata = result_q[data_width-1:apb_data_width];
			default: prdata = '0;
			endcase
		end
	end

	assign ctrl.a = a_q;
	assign ctrl.b = b_q;
	assign ctrl.oper = oper_q;
	assign ctrl.signedness = signed_q;
	assign ctrl.width = width_q;

endmodule

/* hdl/alu_top.sv */
`timescale 1ns/1ps

module alu_top
(
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [alu_pkg::apb_addr_width-1:0] paddr,
	input logic [alu_pkg::apb_data_width-1:0] pwdata,
	output logic [alu_pkg::apb_data_width-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	// operands, control and result between registers and datapath
	alu_ctrl_if ctrl_bus ();

	// APB slave and register file
	alu_regs alu_regs_i
	(
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.ctrl(ctrl_bus.regs)
	);

	// combinational ALU for all widths
	alu_width_select alu_width_select_i
	(
		.ctrl(ctrl_bus.datapath)
	);

endmodule

/* hdl/alu_width_select.sv */
`timescale 1ns/1ps

module alu_width_select
(
	alu_ctrl_if.datapath ctrl
);
	import alu_pkg::*;

	localparam int num_cores = 4;

	// zero-extended output of each core
	logic [data_width-1:0] core_result [num_cores];

	genvar i;
	generate
		// widths 8, 16, 32 and 64
		for (i = 0; i < num_cores; i++)
		begin : g_core
			localparam int core_width = 8 << i;

			logic [core_width-1:0] narrow_result;

			alu_core #(.width(core_width)) alu_core_i
			(
				.a(ctrl.a[core_width-1:0]),
				.b(ctrl.b[core_width-1:0]),
				.oper(ctrl.oper),
				.signedness(ctrl.signedness),
				.result(narrow_result)
			);

			assign core_result[i] = data_width'(narrow_result);
		end
	endgenerate

	// pick the core for the selected width
	always_comb
	begin
		case (ctrl.width)
		w8:
		begin
			ctrl.result = core_result[0];
		end
		w16:
		begin
			ctrl.result = core_result[1];
		end
		w32:
		begin
			ctrl.result = core_result[2];
		end
		w64:
		begin
			ctrl.result = core_result[3];
		end
		default:
		begin
			ctrl.result = '0;
		end
		endcase
	end

endmodule

/* list.f */
hdl/alu_pkg.sv
hdl/alu_ctrl_if.sv
hdl/alu_core.sv
hdl/alu_width_select.sv
hdl/alu_regs.sv
hdl/alu_top.sv
bench/alu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module alu_tb -f list.f -o alu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/alu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" sim.log; then
	exit 1
fi
exit 0
